/* dc_bus_pkg.sv */
`default_nettype none

package dc_bus_pkg;

    // All four byte lanes
    localparam logic [3:0] SEL_ALL = 4'b1111;

    // CPU load/store request, held steady until ready
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
        logic [3:0]  be;
    } cpu_req_t;

    // ==================================================
    // Wishbone master side
    // ==================================================

    // stb and cyc always move together
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic        we;
        logic [3:0]  sel;
        logic        stb;
        logic        cyc;
    } wb_req_t;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_resp_t;

    // Transfer kinds run by the bus engine
    typedef enum logic [1:0] {
        OP_LINE_WR,
        OP_LINE_RD,
        OP_SINGLE
    } wb_op_t;

endpackage

`default_nettype wire

/* dc_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module dc_ctrl (
    input  logic                  clk,
    input  logic                  rst,

    // CPU side
    input  dc_bus_pkg::cpu_req_t  cpu_req_i,
    input  logic                  cpu_valid_i,
    output logic [31:0]           cpu_rdata_o,
    output logic                  cpu_ready_o,

    // Line store
    output dc_geom_pkg::l1_addr_t lookup_addr_o,
    input  logic                  hit_i,
    input  dc_geom_pkg::line_t    line_i,
    input  dc_geom_pkg::tag_t     victim_tag_i,
    input  logic                  victim_dirty_i,
    output logic                  hit_we_o,
    output dc_geom_pkg::line_t    hit_line_o,
    output logic                  fill_we_o,
    output dc_geom_pkg::index_t   fill_index_o,
    output dc_geom_pkg::tag_t     fill_tag_o,
    output dc_geom_pkg::line_t    fill_line_o,
    output logic                  fill_dirty_o,

    // Bus engine
    output logic                  start_o,
    output dc_bus_pkg::wb_op_t    op_o,
    output logic [31:0]           base_addr_o,
    output dc_geom_pkg::line_t    wr_line_o,
    output dc_bus_pkg::cpu_req_t  single_req_o,
    input  logic                  done_i,
    input  dc_geom_pkg::line_t    rd_line_i,
    input  logic [31:0]           rd_word_i
);

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL,
        BYPASS
    } state_t;

    state_t                state_q;
    logic                  start_q;

    // Request held across a miss or bypass
    dc_bus_pkg::cpu_req_t  req_q;
    dc_geom_pkg::tag_t     victim_tag_q;

    dc_geom_pkg::l1_addr_t cur_addr;
    dc_geom_pkg::l1_addr_t req_addr;
    logic                  cacheable;
    logic                  hit_ok;
    logic [31:0]           hit_word;
    logic [31:0]           fill_word;

    // ==================================================
    // Classification and lookup
    // ==================================================

    assign cur_addr  = cpu_req_i.addr;
    assign req_addr  = req_q.addr;
    assign cacheable = (cpu_req_i.addr[31:23] == dc_geom_pkg::CACHE_BASE);

    // Store hit counts only inside the cacheable window
    assign hit_ok    = (state_q == IDLE) && cpu_valid_i && cacheable && hit_i;

    // Off IDLE the lookup points at the latched line, the writeback source
    assign lookup_addr_o = (state_q == IDLE) ? cur_addr : req_addr;

    // Write hit merges bytes into the indexed line
    assign hit_word = dc_geom_pkg::merge_bytes(line_i[cur_addr.word],
                                               cpu_req_i.wdata, cpu_req_i.be);

    always_comb begin
        hit_line_o                = line_i;
        hit_line_o[cur_addr.word] = hit_word;
    end

    assign hit_we_o = hit_ok && cpu_req_i.we;

    // ==================================================
    // Fill with write allocate
    // ==================================================

    assign fill_word = dc_geom_pkg::merge_bytes(rd_line_i[req_addr.word],
                                                req_q.wdata, req_q.be);

    always_comb begin
        fill_line_o = rd_line_i;
        if (req_q.we) begin
            fill_line_o[req_addr.word] = fill_word;
        end
    end

    assign fill_we_o    = (state_q == REFILL) && done_i;
    assign fill_index_o = req_addr.index;
    assign fill_tag_o   = req_addr.tag;
    assign fill_dirty_o = req_q.we;

    // ==================================================
    // Bus command
    // ==================================================

    assign start_o      = start_q;
    assign wr_line_o    = line_i;
    assign single_req_o = req_q;

    always_comb begin
        op_o        = dc_bus_pkg::OP_LINE_RD;
        base_addr_o = {req_q.addr[31:4], 4'b0000};
        case (state_q)
            WRITEBACK: begin
                // Victim line address from its old tag
                op_o        = dc_bus_pkg::OP_LINE_WR;
                base_addr_o = {victim_tag_q, req_addr.index, 4'b0000};
            end
            BYPASS:  op_o = dc_bus_pkg::OP_SINGLE;
            default: op_o = dc_bus_pkg::OP_LINE_RD;
        endcase
    end

    // State machine
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (cpu_valid_i && !hit_ok) begin
                        start_q <= 1'b1;
                        if (!cacheable) begin
                            state_q <= BYPASS;
                        end else if (victim_dirty_i) begin
                            state_q <= WRITEBACK;
                        end else begin
                            state_q <= REFILL;
                        end
                    end
                end
                WRITEBACK: begin
                    // Refill follows the last write ack
                    if (done_i) begin
                        state_q <= REFILL;
                        start_q <= 1'b1;
                    end
                end
                default: begin
                    if (done_i) begin
                        state_q <= IDLE;
                    end
                end
            endcase
        end
    end

    // Request and victim tag, captured as IDLE hands off
    always_ff @(posedge clk) begin
        if ((state_q == IDLE) && cpu_valid_i && !hit_ok) begin
            req_q        <= cpu_req_i;
            victim_tag_q <= victim_tag_i;
        end
    end

    // ==================================================
    // CPU response
    // ==================================================

    always_comb begin
        cpu_rdata_o = line_i[cur_addr.word];
        cpu_ready_o = hit_ok;
        case (state_q)
            REFILL: begin
                // Requested word, unmerged, straight from the burst
                cpu_rdata_o = rd_line_i[req_addr.word];
                cpu_ready_o = done_i;
            end
            BYPASS: begin
                cpu_rdata_o = rd_word_i;
                cpu_ready_o = done_i;
            end
            WRITEBACK: cpu_ready_o = 1'b0;
            default:   cpu_ready_o = hit_ok;
        endcase
    end

    a_ready_on_done : assert property (
        @(posedge clk) disable iff (rst)
        (cpu_ready_o && (state_q != IDLE)) |-> done_i
    );

endmodule

`default_nettype wire

/* dc_geom_pkg.sv */
`default_nettype none

package dc_geom_pkg;

    // ==================================================
    // Cache geometry
    // ==================================================

    // 1 KB direct-mapped, 16-byte lines
    localparam int L1_SETS        = 64;
    localparam int WORDS_PER_LINE = 4;
    localparam int TAG_W          = 22;
    localparam int INDEX_W        = 6;
    localparam int WORD_W         = 2;
    localparam int LINE_W         = 128;

    // Address bits 31..23 of the cacheable window 0x8000_0000..0x807F_FFFF
    localparam logic [8:0] CACHE_BASE = 9'b1000_0000_0;

    // ==================================================
    // Types
    // ==================================================

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    // Tag | index | word in line | byte in word
    typedef struct packed {
        tag_t              tag;
        index_t            index;
        logic [WORD_W-1:0] word;
        logic [1:0]        byte_off;
    } l1_addr_t;

    // One cache line, word 0 in the low bits
    typedef logic [WORDS_PER_LINE-1:0][31:0] line_t;

    // Overlay the enabled bytes of a write word on an old word
    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  be
    );
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

endpackage

`default_nettype wire

/* dc_l1_store.sv */
`timescale 1ns/100ps
`default_nettype none

module dc_l1_store (
    input  logic                  clk,
    input  logic                  rst,

    // Lookup port
    input  dc_geom_pkg::l1_addr_t lookup_addr_i,
    output logic                  hit_o,
    output dc_geom_pkg::line_t    line_o,
    output dc_geom_pkg::tag_t     victim_tag_o,
    output logic                  victim_dirty_o,

    // Hit write, at the lookup index
    input  logic                  hit_we_i,
    input  dc_geom_pkg::line_t    hit_line_i,

    // Line fill
    input  logic                  fill_we_i,
    input  dc_geom_pkg::index_t   fill_index_i,
    input  dc_geom_pkg::tag_t     fill_tag_i,
    input  dc_geom_pkg::line_t    fill_line_i,
    input  logic                  fill_dirty_i
);

    // ==================================================
    // Storage
    // ==================================================

    logic [dc_geom_pkg::LINE_W-1:0] data_mem [dc_geom_pkg::L1_SETS];
    dc_geom_pkg::tag_t              tag_mem  [dc_geom_pkg::L1_SETS];

    // Per-line state bits
    logic [dc_geom_pkg::L1_SETS-1:0] valid_q;
    logic [dc_geom_pkg::L1_SETS-1:0] dirty_q;

    dc_geom_pkg::index_t idx;

    assign idx = lookup_addr_i.index;

    // ==================================================
    // Combinational lookup
    // ==================================================

    // Cacheability is judged by the controller
    assign hit_o          = valid_q[idx] && (tag_mem[idx] == lookup_addr_i.tag);
    assign line_o         = data_mem[idx];
    assign victim_tag_o   = tag_mem[idx];

    // Only a valid line can need a writeback
    assign victim_dirty_o = valid_q[idx] && dirty_q[idx];

    // Data and tag arrays
    always_ff @(posedge clk) begin
        if (fill_we_i) begin
            data_mem[fill_index_i] <= fill_line_i;
            tag_mem[fill_index_i]  <= fill_tag_i;
        end else if (hit_we_i) begin
            data_mem[idx] <= hit_line_i;
        end
    end

    // Valid and dirty bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_we_i) begin
            valid_q[fill_index_i] <= 1'b1;
            dirty_q[fill_index_i] <= fill_dirty_i;
        end else if (hit_we_i) begin
            // Write hit leaves the line owed to memory
            dirty_q[idx] <= 1'b1;
        end
    end

    // Controller never overlaps a fill with a hit write
    a_no_dual_write : assert property (
        @(posedge clk) disable iff (rst)
        !(hit_we_i && fill_we_i)
    );

endmodule

`default_nettype wire

/* dc_wb_master.sv */
`timescale 1ns/100ps
`default_nettype none

module dc_wb_master (
    input  logic                  clk,
    input  logic                  rst,

    // Command from the controller
    input  logic                  start_i,
    input  dc_bus_pkg::wb_op_t    op_i,
    input  logic [31:0]           base_addr_i,
    input  dc_geom_pkg::line_t    wr_line_i,
    input  dc_bus_pkg::cpu_req_t  single_req_i,

    // Wishbone
    output dc_bus_pkg::wb_req_t   wb_req_o,
    input  dc_bus_pkg::wb_resp_t  wb_resp_i,

    // Completion
    output logic                  done_o,
    output dc_geom_pkg::line_t    rd_line_o,
    output logic [31:0]           rd_word_o
);

    logic                             busy_q;
    dc_bus_pkg::wb_op_t               op_q;
    logic [31:0]                      base_q;
    logic [dc_geom_pkg::WORD_W-1:0]   beat_q;

    // First three words of a line read
    logic [2:0][31:0]                 rd_buf_q;

    logic                             single;
    logic                             last_beat;
    logic                             beat_done;

    assign single    = (op_q == dc_bus_pkg::OP_SINGLE);
    assign last_beat = single ||
                       (beat_q == 2'(dc_geom_pkg::WORDS_PER_LINE - 1));
    assign beat_done = busy_q && wb_resp_i.ack;

    // Pulse on the final ack only
    assign done_o    = beat_done && last_beat;

    // Last word passes straight through on done
    assign rd_line_o = {wb_resp_i.dat, rd_buf_q};
    assign rd_word_o = wb_resp_i.dat;

    // ==================================================
    // Sequencing
    // ==================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= 1'b0;
            op_q   <= dc_bus_pkg::OP_LINE_RD;
            beat_q <= '0;
        end else if (start_i && !busy_q) begin
            busy_q <= 1'b1;
            op_q   <= op_i;
            beat_q <= '0;
        end else if (beat_done) begin
            // Advance only on ack so a stalled beat holds still
            beat_q <= beat_q + 1'b1;
            if (last_beat) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Burst base and read words
    always_ff @(posedge clk) begin
        if (start_i && !busy_q) begin
            base_q <= base_addr_i;
        end
        if (beat_done && (op_q == dc_bus_pkg::OP_LINE_RD) && !last_beat) begin
            rd_buf_q[beat_q] <= wb_resp_i.dat;
        end
    end

    // ==================================================
    // Bus drive
    // ==================================================

    always_comb begin
        wb_req_o     = '0;
        wb_req_o.stb = busy_q;
        wb_req_o.cyc = busy_q;
        if (busy_q) begin
            if (single) begin
                wb_req_o.adr = single_req_i.addr;
                wb_req_o.dat = single_req_i.wdata;
                wb_req_o.we  = single_req_i.we;
                wb_req_o.sel = single_req_i.be;
            end else begin
                // Line base plus four bytes per beat
                wb_req_o.adr = base_q + {28'b0, beat_q, 2'b00};
                wb_req_o.dat = wr_line_i[beat_q];
                wb_req_o.we  = (op_q == dc_bus_pkg::OP_LINE_WR);
                wb_req_o.sel = dc_bus_pkg::SEL_ALL;
            end
        end
    end

    a_stb_needs_cyc : assert property (
        @(posedge clk) disable iff (rst)
        wb_req_o.stb |-> wb_req_o.cyc
    );

    // Unacked beat keeps its address for the next cycle
    a_stall_holds_adr : assert property (
        @(posedge clk) disable iff (rst)
        (wb_req_o.stb && !wb_resp_i.ack) |=> (wb_req_o.stb && $stable(wb_req_o.adr))
    );

endmodule

`default_nettype wire

/* dcache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,

    // CPU load/store port
    input  dc_bus_pkg::cpu_req_t cpu_req_i,
    input  logic                 cpu_valid_i,
    output logic [31:0]          cpu_rdata_o,
    output logic                 cpu_ready_o,

    // Wishbone master port
    output dc_bus_pkg::wb_req_t  wb_req_o,
    input  dc_bus_pkg::wb_resp_t wb_resp_i
);

    // Controller to line store
    dc_geom_pkg::l1_addr_t lookup_addr;
    logic                  hit;
    dc_geom_pkg::line_t    line;
    dc_geom_pkg::tag_t     victim_tag;
    logic                  victim_dirty;
    logic                  hit_we;
    dc_geom_pkg::line_t    hit_line;
    logic                  fill_we;
    dc_geom_pkg::index_t   fill_index;
    dc_geom_pkg::tag_t     fill_tag;
    dc_geom_pkg::line_t    fill_line;
    logic                  fill_dirty;

    // Controller to bus engine
    logic                  start;
    dc_bus_pkg::wb_op_t    op;
    logic [31:0]           base_addr;
    dc_geom_pkg::line_t    wr_line;
    dc_bus_pkg::cpu_req_t  single_req;
    logic                  done;
    dc_geom_pkg::line_t    rd_line;
    logic [31:0]           rd_word;

    dc_ctrl dc_ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_i      (cpu_req_i),
        .cpu_valid_i    (cpu_valid_i),
        .cpu_rdata_o    (cpu_rdata_o),
        .cpu_ready_o    (cpu_ready_o),
        .lookup_addr_o  (lookup_addr),
        .hit_i          (hit),
        .line_i         (line),
        .victim_tag_i   (victim_tag),
        .victim_dirty_i (victim_dirty),
        .hit_we_o       (hit_we),
        .hit_line_o     (hit_line),
        .fill_we_o      (fill_we),
        .fill_index_o   (fill_index),
        .fill_tag_o     (fill_tag),
        .fill_line_o    (fill_line),
        .fill_dirty_o   (fill_dirty),
        .start_o        (start),
        .op_o           (op),
        .base_addr_o    (base_addr),
        .wr_line_o      (wr_line),
        .single_req_o   (single_req),
        .done_i         (done),
        .rd_line_i      (rd_line),
        .rd_word_i      (rd_word)
    );

    dc_l1_store dc_l1_store_i (
        .clk            (clk),
        .rst            (rst),
        .lookup_addr_i  (lookup_addr),
        .hit_o          (hit),
        .line_o         (line),
        .victim_tag_o   (victim_tag),
        .victim_dirty_o (victim_dirty),
        .hit_we_i       (hit_we),
        .hit_line_i     (hit_line),
        .fill_we_i      (fill_we),
        .fill_index_i   (fill_index),
        .fill_tag_i     (fill_tag),
        .fill_line_i    (fill_line),
        .fill_dirty_i   (fill_dirty)
    );

    dc_wb_master dc_wb_master_i (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start),
        .op_i           (op),
        .base_addr_i    (base_addr),
        .wr_line_i      (wr_line),
        .single_req_i   (single_req),
        .wb_req_o       (wb_req_o),
        .wb_resp_i      (wb_resp_i),
        .done_o         (done),
        .rd_line_o      (rd_line),
        .rd_word_o      (rd_word)
    );

endmodule

`default_nettype wire

/* filelist.f */
dc_geom_pkg.sv
dc_bus_pkg.sv
dc_l1_store.sv
dc_wb_master.sv
dc_ctrl.sv
dcache_top.sv
tb_wb_mem.sv
tb_dcache.sv

/* tb_dcache.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dcache;

    // Same preload rule as the memory model
    localparam logic [31:0] FILL_KEY = 32'h5a5a_c3c3;

    typedef struct {
        string       name;
        logic [31:0] addr;
        logic        we;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic [31:0] exp_rdata;
    } stim_t;

    logic                 clk;
    logic                 rst;
    dc_bus_pkg::cpu_req_t cpu_req;
    logic                 cpu_valid;
    logic [31:0]          cpu_rdata;
    logic                 cpu_ready;
    dc_bus_pkg::wb_req_t  wb_req;
    dc_bus_pkg::wb_resp_t wb_resp;

    // Architectural memory and resident line tags
    logic [31:0]          shadow_mem [4096];
    dc_geom_pkg::tag_t    sh_tag [64];
    logic [63:0]          sh_valid;
    logic [63:0]          sh_dirty;
    stim_t                stim_q [$];

    dcache_top dcache_top_i (
        .clk         (clk),
        .rst         (rst),
        .cpu_req_i   (cpu_req),
        .cpu_valid_i (cpu_valid),
        .cpu_rdata_o (cpu_rdata),
        .cpu_ready_o (cpu_ready),
        .wb_req_o    (wb_req),
        .wb_resp_i   (wb_resp)
    );

    tb_wb_mem wb_mem_i (
        .clk       (clk),
        .rst       (rst),
        .wb_req_i  (wb_req),
        .wb_resp_o (wb_resp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==================================================
    // Reporting and compares
    // ==================================================

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // Write data only matters on write beats
    task automatic check_wb_req(input string name, input dc_bus_pkg::wb_req_t exp,
                                input dc_bus_pkg::wb_req_t act);
        string exp_s;
        string act_s;
        if ((act.adr !== exp.adr) || (act.we !== exp.we) || (act.sel !== exp.sel) ||
            (exp.we && (act.dat !== exp.dat))) begin
            exp_s = $sformatf("adr=%h we=%b sel=%h dat=%h", exp.adr, exp.we, exp.sel, exp.dat);
            act_s = $sformatf("adr=%h we=%b sel=%h dat=%h", act.adr, act.we, act.sel, act.dat);
            abort_run({"CHECK FAILED ", name, ": expected ", exp_s, ", actual ", act_s});
        end
    endtask

    // ==================================================
    // Reference model
    // ==================================================

    // Cacheable window 0x8000_0000 to 0x807F_FFFF
    function automatic logic is_cacheable(input logic [31:0] addr);
        return (addr >= 32'h8000_0000) && (addr <= 32'h807f_ffff);
    endfunction

    // Byte-lane mask blend
    function automatic logic [31:0] overlay(input logic [31:0] old_w, input logic [31:0] new_w,
                                            input logic [3:0] be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    // One burst beat at line base plus four bytes per beat
    function automatic dc_bus_pkg::wb_req_t line_beat(input logic [31:0] base, input int k,
                                                      input logic we);
        dc_bus_pkg::wb_req_t beat;
        beat     = '0;
        beat.adr = base + 32'(4 * k);
        beat.dat = we ? shadow_mem[base[13:2] + 12'(k)] : 32'h0;
        beat.we  = we;
        beat.sel = dc_bus_pkg::SEL_ALL;
        beat.stb = 1'b1;
        beat.cyc = 1'b1;
        return beat;
    endfunction

    function automatic stim_t make_stim(input string name, input logic [31:0] addr,
                                       input logic we, input logic [31:0] wdata,
                                       input logic [3:0] be, input logic [31:0] exp_rdata);
        stim_t s;
        s.name      = name;
        s.addr      = addr;
        s.we        = we;
        s.wdata     = wdata;
        s.be        = be;
        s.exp_rdata = exp_rdata;
        return s;
    endfunction

    // Model memory must match except lines still dirty in the cache
    task automatic check_memory(input string name);
        dc_geom_pkg::l1_addr_t a;
        for (int i = 0; i < 4096; i++) begin
            a = 32'h8000_0000 | 32'(i << 2);
            if (!(sh_valid[a.index] && sh_dirty[a.index] && (sh_tag[a.index] == a.tag))) begin
                check_word($sformatf("%s mem[%0d]", name, i), shadow_mem[i], wb_mem_i.mem[i]);
            end
        end
    endtask

    // ==================================================
    // Request driver
    // ==================================================

    task automatic run_request(input stim_t s);
        dc_bus_pkg::wb_req_t   exp_q [$];
        dc_bus_pkg::wb_req_t   beat;
        dc_geom_pkg::l1_addr_t a;
        logic [31:0]           rdata;
        logic                  hit;
        logic                  cyc_seen;
        logic                  done;
        int                    waited;
        a   = s.addr;
        hit = is_cacheable(s.addr) && sh_valid[a.index] && (sh_tag[a.index] == a.tag);
        // Expected Wishbone beats in order
        if (!is_cacheable(s.addr)) begin
            beat     = '0;
            beat.adr = s.addr;
            beat.dat = s.wdata;
            beat.we  = s.we;
            beat.sel = s.be;
            exp_q.push_back(beat);
        end else if (!hit) begin
            if (sh_valid[a.index] && sh_dirty[a.index]) begin
                for (int k = 0; k < 4; k++) begin
                    exp_q.push_back(line_beat({sh_tag[a.index], a.index, 4'b0000}, k, 1'b1));
                end
            end
            for (int k = 0; k < 4; k++) begin
                exp_q.push_back(line_beat({s.addr[31:4], 4'b0000}, k, 1'b0));
            end
        end
        @(posedge clk);
        #1;
        cpu_req.addr  = s.addr;
        cpu_req.wdata = s.wdata;
        cpu_req.we    = s.we;
        cpu_req.be    = s.be;
        cpu_valid     = 1'b1;
        waited        = 0;
        cyc_seen      = 1'b0;
        done          = 1'b0;
        // One look per cycle at the falling edge
        while (!done) begin
            @(negedge clk);
            cyc_seen = cyc_seen | wb_req.cyc;
            if (wb_req.stb && wb_resp.ack) begin
                if (exp_q.size() == 0) begin
                    abort_run($sformatf("unexpected Wishbone beat in test %s", s.name));
                end else begin
                    check_wb_req(s.name, exp_q.pop_front(), wb_req);
                end
            end
            if (cpu_ready) begin
                done  = 1'b1;
                rdata = cpu_rdata;
            end else if (waited == 200) begin
                abort_run($sformatf("request never completed in test %s", s.name));
            end else begin
                waited++;
            end
        end
        @(posedge clk);
        #1;
        cpu_valid = 1'b0;
        if (exp_q.size() != 0) begin
            abort_run($sformatf("fewer Wishbone beats than expected in test %s", s.name));
        end
        if (hit) begin
            check_bit({s.name, " ready in valid cycle"}, 1'b1, waited == 0);
            check_bit({s.name, " cyc low"}, 1'b0, cyc_seen);
        end
        if (!s.we) begin
            check_word(s.name, s.exp_rdata, rdata);
        end
        // Advance the shadow state
        if (s.we) begin
            shadow_mem[s.addr[13:2]] = overlay(shadow_mem[s.addr[13:2]], s.wdata, s.be);
        end
        if (is_cacheable(s.addr)) begin
            sh_dirty[a.index] = hit ? (sh_dirty[a.index] | s.we) : s.we;
            sh_valid[a.index] = 1'b1;
            sh_tag[a.index]   = a.tag;
        end
        check_memory(s.name);
    endtask

    // ==================================================
    // Stimulus
    // ==================================================

    initial begin
        rst       = 1'b1;
        cpu_req   = '0;
        cpu_valid = 1'b0;
        sh_valid  = '0;
        sh_dirty  = '0;
        void'($urandom(32'h38af));
        for (int k = 0; k < 256; k++) begin
            wb_mem_i.delay_tab[k] = 2'($urandom % 4);
        end
        for (int i = 0; i < 4096; i++) begin
            shadow_mem[i] = 32'(i << 2) ^ FILL_KEY;
        end
        // Lines at index 20 and 32 with tag 0, later hit by tag 1 conflicts
        stim_q.push_back(make_stim("read_miss", 32'h8000_0148, 1'b0, 32'h0, 4'hf, 32'h5a5a_c28b));
        stim_q.push_back(make_stim("read_hit", 32'h8000_0144, 1'b0, 32'h0, 4'hf, 32'h5a5a_c287));
        stim_q.push_back(make_stim("write_hit", 32'h8000_0144, 1'b1, 32'ha1b2_c3d4,
                                   4'b0101, 32'h0));
        stim_q.push_back(make_stim("read_merged", 32'h8000_0144, 1'b0, 32'h0, 4'hf, 32'h5ab2_c2d4));
        stim_q.push_back(make_stim("write_alloc", 32'h8000_0208, 1'b1, 32'h1122_3344,
                                   4'b0011, 32'h0));
        stim_q.push_back(make_stim("read_alloc", 32'h8000_0208, 1'b0, 32'h0, 4'hf, 32'h5a5a_3344));
        stim_q.push_back(make_stim("evict_dirty", 32'h8000_0544, 1'b0, 32'h0, 4'hf, 32'h5a5a_c687));
        stim_q.push_back(make_stim("read_evicted", 32'h8000_0144, 1'b0, 32'h0, 4'hf,
                                   32'h5ab2_c2d4));
        stim_q.push_back(make_stim("bypass_write", 32'h1000_0000, 1'b1, 32'hcafe_f00d,
                                   4'b1100, 32'h0));
        stim_q.push_back(make_stim("bypass_read", 32'h1000_0000, 1'b0, 32'h0, 4'hf, 32'hcafe_c3c3));
        stim_q.push_back(make_stim("write_evict", 32'h8000_0600, 1'b1, 32'h7700_0000,
                                   4'b1000, 32'h0));
        stim_q.push_back(make_stim("read_evict_wa", 32'h8000_0208, 1'b0, 32'h0, 4'hf,
                                   32'h5a5a_3344));
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (stim_q[n]) begin
            run_request(stim_q[n]);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_wb_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_wb_mem (
    input  logic                 clk,
    input  logic                 rst,

    // Wishbone slave side
    input  dc_bus_pkg::wb_req_t  wb_req_i,
    output dc_bus_pkg::wb_resp_t wb_resp_o
);

    // Word value is its byte offset XOR this key
    localparam logic [31:0] FILL_KEY  = 32'h5a5a_c3c3;
    localparam int          MEM_WORDS = 4096;

    // ==================================================
    // Storage, visible to the testbench
    // ==================================================

    logic [31:0] mem [MEM_WORDS];

    // Ack delay per beat, loaded by the testbench from its seeded stream
    logic [1:0]  delay_tab [256];
    logic [7:0]  delay_ptr_q;

    // Cycles the current beat has been held
    logic [1:0]  wait_q;
    logic [11:0] word_idx;
    logic        active;

    // 16 KB window, same words behind both base addresses
    assign word_idx = wb_req_i.adr[13:2];
    assign active   = wb_req_i.stb && wb_req_i.cyc;

    always_comb begin
        wb_resp_o.dat = mem[word_idx];
        // Ack once the beat has waited its drawn delay
        wb_resp_o.ack = active && (wait_q == delay_tab[delay_ptr_q]);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_q      <= '0;
            delay_ptr_q <= '0;
            // Preload while reset is held
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= {18'b0, 12'(i), 2'b00} ^ FILL_KEY;
            end
        end else if (active) begin
            if (wb_resp_o.ack) begin
                wait_q      <= '0;
                delay_ptr_q <= delay_ptr_q + 1'b1;
                if (wb_req_i.we) begin
                    // Only selected byte lanes change
                    for (int b = 0; b < 4; b++) begin
                        if (wb_req_i.sel[b]) begin
                            mem[word_idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
                        end
                    end
                end
            end else begin
                wait_q <= wait_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
